// ==== all.f ====
source/fetch_pkg.sv
source/imem_sram.sv
source/fetch_cfg_regs.sv
source/fetch_stage.sv
source/branch_predict.sv
source/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module fetch_tb \
    -f all.f \
    -o fetch_sim

# a failing run exits non-zero, the log decides the result
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== source/branch_predict.sv ====
`timescale 1ns/1ns

module branch_predict
    import fetch_pkg::*;
(
    input  logic  valid_i,              // output item present
    input  logic  ready_i,              // consumer takes it this cycle
    input  xlen_t pc_i,
    input  xlen_t inst_i,
    output logic  redirect_o,
    output xlen_t redirect_target_o,
    output logic  pred_taken_o
);

    br_class_e br_class;
    xlen_t     imm_j;                   // jal offset
    xlen_t     imm_b;                   // conditional branch offset
    xlen_t     offset;
    logic      taken;

    // ========================================
    // classify
    // ========================================
    always_comb begin
        case (inst_i[6:0])
            OPC_JAL: begin
                br_class = BR_JAL;
            end
            OPC_BRANCH: begin
                // sign bit of the b-immediate tells the direction
                br_class = inst_i[31] ? BR_COND_BACK : BR_COND_FWD;
            end
            default: begin
                br_class = BR_NONE;
            end
        endcase
    end

    // ========================================
    // immediates
    // ========================================
    // j-type: imm[20|10:1|11|19:12] in inst[31:12]
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // b-type: imm[12|10:5] in inst[31:25], imm[4:1|11] in inst[11:7]
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};

    // ========================================
    // backward taken, forward not taken
    // ========================================
    always_comb begin
        case (br_class)
            BR_JAL: begin
                taken  = 1'b1;
                offset = imm_j;
            end
            BR_COND_BACK: begin
                taken  = 1'b1;
                offset = imm_b;
            end
            default: begin
                taken  = 1'b0;          // fwd branch and plain words fall through
                offset = PC_STEP;
            end
        endcase
    end

    // target is the predicted next pc, pc+4 when not taken
    assign redirect_target_o = pc_i + offset;
    assign pred_taken_o      = valid_i && taken;
    assign redirect_o        = pred_taken_o && ready_i;   // only on transfer

endmodule

// ==== source/fetch_cfg_regs.sv ====
`timescale 1ns/1ns

module fetch_cfg_regs
    import fetch_pkg::*;
#(
    parameter int IMEM_AW = 10
) (
    input  logic               clk,
    input  logic               resetn,

    // host command port
    input  logic               cfg_valid_i,
    input  cfg_op_e            cfg_op_i,
    input  logic [IMEM_AW-1:0] cfg_addr_i,
    input  xlen_t              cfg_data_i,
    output logic               cfg_ready_o,

    // imem write port
    output logic               mem_we_o,
    output logic [IMEM_AW-1:0] mem_waddr_o,
    output xlen_t              mem_wdata_o,

    // fetch control
    output logic               run_o,
    output logic               start_o,
    output xlen_t              boot_pc_o
);

    logic               run_q;
    logic               start_q;
    xlen_t              boot_pc_q;
    logic               we_q;
    logic [IMEM_AW-1:0] waddr_q;
    xlen_t              wdata_q;

    logic cmd_acc;                      // command taken this cycle
    logic halt_acc;

    // ========================================
    // handshake
    // ========================================
    // halted: take anything. running: only a halt gets through
    assign cfg_ready_o = !run_q || (cfg_op_i == CFG_HALT);
    assign cmd_acc     = cfg_valid_i && cfg_ready_o;
    assign halt_acc    = cmd_acc && (cfg_op_i == CFG_HALT);

    // ========================================
    // command decode
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            run_q     <= 1'b0;
            start_q   <= 1'b0;
            boot_pc_q <= '0;
            we_q      <= 1'b0;
        end else begin
            start_q <= cmd_acc && (cfg_op_i == CFG_RUN);         // single cycle
            we_q    <= cmd_acc && (cfg_op_i == CFG_LOAD_WORD);
            if (cmd_acc && (cfg_op_i == CFG_SET_BOOT)) begin
                boot_pc_q <= cfg_data_i;
            end
            if (halt_acc) begin
                run_q <= 1'b0;
            end else if (cmd_acc && (cfg_op_i == CFG_RUN)) begin
                run_q <= 1'b1;
            end
        end
    end

    // write payload, qualified by we_q
    always_ff @(posedge clk) begin
        waddr_q <= cfg_addr_i;
        wdata_q <= cfg_data_i;
    end

    assign mem_we_o    = we_q;
    assign mem_waddr_o = waddr_q;
    assign mem_wdata_o = wdata_q;
    assign start_o     = start_q;
    assign boot_pc_o   = boot_pc_q;
    assign run_o       = run_q && !halt_acc;    // drops in the halt cycle itself

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // ========================================
    // widths and basic types
    // ========================================
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;    // instruction or byte address

    localparam xlen_t PC_STEP = 32'd4;  // one 32-bit instruction, no compressed

    // ========================================
    // configuration command opcodes
    // ========================================
    typedef enum logic [1:0] {
        CFG_LOAD_WORD = 2'd0,   // write one instruction word into imem
        CFG_SET_BOOT  = 2'd1,   // latch the boot pc
        CFG_RUN       = 2'd2,   // start fetching at the boot pc
        CFG_HALT      = 2'd3    // stop and drop in-flight items
    } cfg_op_e;

    // ========================================
    // branch classes seen by the predictor
    // ========================================
    typedef enum logic [1:0] {
        BR_NONE      = 2'd0,    // not a control transfer we predict
        BR_JAL       = 2'd1,    // unconditional, always taken
        BR_COND_BACK = 2'd2,    // negative offset, assume loop, taken
        BR_COND_FWD  = 2'd3     // positive offset, not taken
    } br_class_e;

    // rv32i major opcodes, inst[6:0]
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

endpackage

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage
    import fetch_pkg::*;
#(
    parameter int IMEM_AW = 10
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               run_i,             // low clears everything in flight
    input  logic               start_i,           // pulse that loads the boot pc
    input  xlen_t              boot_pc_i,
    input  logic               redirect_i,        // taken item is transferring now
    input  xlen_t              redirect_target_i,
    output logic [IMEM_AW-1:0] imem_raddr_o,
    input  xlen_t              imem_rdata_i,
    output logic               valid_o,
    input  logic               ready_i,
    output xlen_t              pc_o,
    output xlen_t              pc_plus4_o,
    output xlen_t              inst_o
);

    xlen_t pc_q;                    // next sequential pc
    logic  req_valid_q;             // a read is outstanding in imem
    xlen_t req_pc_q;                // pc of that read
    logic  out_valid_q;
    xlen_t out_pc_q;
    xlen_t out_pc4_q;
    xlen_t out_inst_q;

    logic  out_free;                // output register can take a new item
    logic  issue;                   // a new pc goes to memory this cycle
    xlen_t issue_pc;

    // ========================================
    // next pc and issue control
    // ========================================
    assign out_free = !out_valid_q || ready_i;
    assign issue    = run_i && (!req_valid_q || out_free);

    // start beats redirect beats sequential
    always_comb begin
        if (start_i) begin
            issue_pc = boot_pc_i;
        end else if (redirect_i) begin
            issue_pc = redirect_target_i;
        end else begin
            issue_pc = pc_q;
        end
    end

    // on a stall the held request address goes out again
    assign imem_raddr_o = issue ? issue_pc[IMEM_AW+1:2] : req_pc_q[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_q <= '0;
        end else if (issue) begin
            pc_q <= issue_pc + PC_STEP;
        end
    end

    // ========================================
    // request register, lines up with imem latency
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn || !run_i) begin
            req_valid_q <= 1'b0;
        end else if (issue) begin
            req_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc_q <= issue_pc;
        end
    end

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn || !run_i) begin
            out_valid_q <= 1'b0;
        end else if (out_free) begin
            out_valid_q <= req_valid_q && !redirect_i;  // squash wrong path
        end
    end

    always_ff @(posedge clk) begin
        if (out_free && req_valid_q) begin
            out_pc_q   <= req_pc_q;
            out_pc4_q  <= req_pc_q + PC_STEP;
            out_inst_q <= imem_rdata_i;
        end
    end

    assign valid_o    = out_valid_q;
    assign pc_o       = out_pc_q;
    assign pc_plus4_o = out_pc4_q;
    assign inst_o     = out_inst_q;

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top
    import fetch_pkg::*;
#(
    parameter int IMEM_AW = 10              // 1024 instruction words
) (
    input  logic               clk,
    input  logic               resetn,

    // configuration port
    input  logic               cfg_valid_i,
    input  cfg_op_e            cfg_op_i,
    input  logic [IMEM_AW-1:0] cfg_addr_i,
    input  xlen_t              cfg_data_i,
    output logic               cfg_ready_o,

    // instruction port
    output logic               valid_o,
    input  logic               ready_i,
    output xlen_t              pc_o,
    output xlen_t              pc_plus4_o,
    output xlen_t              inst_o,
    output logic               pred_taken_o,
    output xlen_t              pred_target_o
);

    // ========================================
    // internal nets
    // ========================================
    logic               mem_we;
    logic [IMEM_AW-1:0] mem_waddr;
    xlen_t              mem_wdata;
    logic [IMEM_AW-1:0] mem_raddr;
    xlen_t              mem_rdata;
    logic               run;
    logic               start;              // pulse after CFG_RUN
    xlen_t              boot_pc;
    logic               redirect;
    xlen_t              redirect_target;

    fetch_cfg_regs #(.IMEM_AW(IMEM_AW)) u_cfg (
        .clk(clk), .resetn(resetn),
        .cfg_valid_i(cfg_valid_i), .cfg_op_i(cfg_op_i),
        .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i), .cfg_ready_o(cfg_ready_o),
        .mem_we_o(mem_we), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata),
        .run_o(run), .start_o(start), .boot_pc_o(boot_pc)
    );

    imem_sram #(.IMEM_AW(IMEM_AW)) u_imem (
        .clk(clk), .we_i(mem_we), .waddr_i(mem_waddr), .wdata_i(mem_wdata),
        .raddr_i(mem_raddr), .rdata_o(mem_rdata)
    );

    fetch_stage #(.IMEM_AW(IMEM_AW)) u_fetch (
        .clk(clk), .resetn(resetn), .run_i(run), .start_i(start), .boot_pc_i(boot_pc),
        .redirect_i(redirect), .redirect_target_i(redirect_target),
        .imem_raddr_o(mem_raddr), .imem_rdata_i(mem_rdata),
        .valid_o(valid_o), .ready_i(ready_i),
        .pc_o(pc_o), .pc_plus4_o(pc_plus4_o), .inst_o(inst_o)
    );

    // decode slot, looks at the item sitting on the output port
    branch_predict u_bp (
        .valid_i(valid_o), .ready_i(ready_i), .pc_i(pc_o), .inst_i(inst_o),
        .redirect_o(redirect), .redirect_target_o(redirect_target),
        .pred_taken_o(pred_taken_o)
    );

    assign pred_target_o = redirect_target;

endmodule

// ==== source/imem_sram.sv ====
`timescale 1ns/1ns

module imem_sram
    import fetch_pkg::*;
#(
    parameter int IMEM_AW = 10              // word address width
) (
    input  logic               clk,

    // write port, driven by the config block
    input  logic               we_i,
    input  logic [IMEM_AW-1:0] waddr_i,
    input  xlen_t              wdata_i,

    // read port, driven by fetch
    input  logic [IMEM_AW-1:0] raddr_i,
    output xlen_t              rdata_o
);

    localparam int DEPTH = 1 << IMEM_AW;

    // ========================================
    // storage
    // ========================================
    xlen_t mem [DEPTH];                     // contents survive reset
    xlen_t rdata_q;

    // write side, lands on the edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, data valid one cycle after the address
    // fetch re-presents the same address while stalled so this
    // register keeps showing the stalled word
    always_ff @(posedge clk) begin
        rdata_q <= mem[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

// ==== verif/fetch_checker.sv ====
`timescale 1ns/1ns

module fetch_checker
    import fetch_pkg::*;
(
    input logic    clk,
    input logic    resetn,
    input logic    cfg_valid_i,
    input cfg_op_e cfg_op_i,
    input logic    cfg_ready_i,
    input logic    out_valid_i,
    input logic    out_ready_i,
    input xlen_t   pc_i,
    input xlen_t   pc_plus4_i,
    input xlen_t   inst_i,
    input xlen_t   pred_target_i
);

    logic halt_acc;                         // halt taken on this edge

    assign halt_acc = cfg_valid_i && cfg_ready_i && (cfg_op_i == CFG_HALT);

    // ========================================
    // output handshake rules
    // ========================================
    // blocked item stays put until taken, only a halt may drop it
    a_stall_stable: assert property (@(posedge clk) disable iff (!resetn)
        out_valid_i && !out_ready_i && !halt_acc |=>
            out_valid_i && $stable(pc_i) && $stable(pc_plus4_i) &&
            $stable(inst_i) && $stable(pred_target_i))
        else $error("output item changed while stalled");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
        out_valid_i |-> (pc_i[1:0] == 2'b00))
        else $error("pc on the output port is not word aligned");

    a_halt_clears: assert property (@(posedge clk) disable iff (!resetn)
        halt_acc |=> !out_valid_i)
        else $error("valid still high in the cycle after a halt");

endmodule

bind fetch_top fetch_checker u_fetch_checker (
    .clk(clk), .resetn(resetn),
    .cfg_valid_i(cfg_valid_i), .cfg_op_i(cfg_op_i), .cfg_ready_i(cfg_ready_o),
    .out_valid_i(valid_o), .out_ready_i(ready_i),
    .pc_i(pc_o), .pc_plus4_i(pc_plus4_o), .inst_i(inst_o), .pred_target_i(pred_target_o)
);

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb
    import fetch_pkg::*;
();

    localparam int IMEM_AW      = 10;
    localparam int DEPTH        = 1 << IMEM_AW;
    localparam int CFG_TIMEOUT  = 32;       // cycles a command may wait for cfg_ready_o
    localparam int ITEM_TIMEOUT = 64;       // cycles allowed between two transfers
    localparam int N_PROG       = 8;
    localparam int N_PATCH      = 2;
    localparam int N_TEST       = 6;

    logic               clk;
    logic               resetn;
    logic               cfg_valid_i;
    cfg_op_e            cfg_op_i;
    logic [IMEM_AW-1:0] cfg_addr_i;
    xlen_t              cfg_data_i;
    logic               cfg_ready_o;
    logic               valid_o;
    logic               ready_i;
    xlen_t              pc_o;
    xlen_t              pc_plus4_o;
    xlen_t              inst_o;
    logic               pred_taken_o;
    xlen_t              pred_target_o;

    xlen_t ref_inst   [DEPTH];              // reference image of imem
    logic  ref_taken  [DEPTH];              // expected prediction per word
    xlen_t ref_target [DEPTH];              // predicted next pc, pc+4 if not taken
    logic [31:0] lfsr_q;

    // ========================================
    // program: loop 80..b8 with fwd beq, jal and backward bne
    // ========================================
    xlen_t prog_pc     [N_PROG] = '{32'h80, 32'h84, 32'h88, 32'h8c,
                                    32'h90, 32'hb0, 32'hb4, 32'hb8};
    xlen_t prog_inst   [N_PROG] = '{32'h0010_0093,   // addi x1,x0,1
                                    32'h0020_0113,   // addi x2,x0,2
                                    32'h0020_8663,   // beq x1,x2,+12 fwd
                                    32'h0030_0193,   // addi x3,x0,3
                                    32'h0200_006f,   // jal x0,+0x20
                                    32'h0040_0213,   // addi x4,x0,4
                                    32'h0050_0293,   // addi x5,x0,5
                                    32'hfc00_94e3};  // bne x1,x0,-0x38 back
    logic  prog_taken  [N_PROG] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    xlen_t prog_target [N_PROG] = '{32'h84, 32'h88, 32'h8c, 32'h90,
                                    32'hb0, 32'hb4, 32'hb8, 32'h80};

    // reload contents, new addi at 84 and jal retargeted to c0
    xlen_t patch_pc     [N_PATCH] = '{32'h84, 32'h90};
    xlen_t patch_inst   [N_PATCH] = '{32'h0550_0113, 32'h0300_006f};
    logic  patch_taken  [N_PATCH] = '{1'b0, 1'b1};
    xlen_t patch_target [N_PATCH] = '{32'h88, 32'hc0};

    // ========================================
    // test table
    // ========================================
    string t_name  [N_TEST] = '{"seq_boot40", "branch_loop", "seq_backpressure",
                                "branch_backpressure", "load_while_running", "reload"};
    xlen_t t_boot  [N_TEST] = '{32'h40, 32'h80, 32'h40, 32'h80, 32'h80, 32'h80};
    int    t_count [N_TEST] = '{12, 12, 24, 20, 10, 10};
    logic  t_bp    [N_TEST] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};     // lfsr on ready_i
    logic  t_probe [N_TEST] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};     // load offered while running
    logic  t_patch [N_TEST] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};     // reload before run

    fetch_top #(.IMEM_AW(IMEM_AW)) u_fetch_top (
        .clk(clk), .resetn(resetn),
        .cfg_valid_i(cfg_valid_i), .cfg_op_i(cfg_op_i), .cfg_addr_i(cfg_addr_i),
        .cfg_data_i(cfg_data_i), .cfg_ready_o(cfg_ready_o),
        .valid_o(valid_o), .ready_i(ready_i), .pc_o(pc_o), .pc_plus4_o(pc_plus4_o),
        .inst_o(inst_o), .pred_taken_o(pred_taken_o), .pred_target_o(pred_target_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                   // 4 ns period

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic next_lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    // addi x1,x0,<word index>, never a control transfer
    function automatic xlen_t fill_word(input int idx);
        logic [IMEM_AW-1:0] a;
        a = idx[IMEM_AW-1:0];
        return {2'b00, a, 5'd0, 3'b000, 5'd1, 7'b001_0011};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ========================================
    // config port
    // ========================================
    task automatic send_cfg(input cfg_op_e op, input logic [IMEM_AW-1:0] addr,
                            input xlen_t data);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        cfg_valid_i = 1'b1;
        cfg_op_i    = op;
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        @(negedge clk);
        while (!cfg_ready_o) begin
            waited++;
            if (waited > CFG_TIMEOUT) begin
                fail_run($sformatf("timeout: config command %s was never accepted",
                                   op.name()));
            end
            @(negedge clk);
        end
        @(posedge clk);                     // taken on this edge
        #1;
        cfg_valid_i = 1'b0;
    endtask

    task automatic load_word(input xlen_t pc, input xlen_t inst, input logic taken,
                             input xlen_t target);
        send_cfg(CFG_LOAD_WORD, pc[IMEM_AW+1:2], inst);
        ref_inst[pc[IMEM_AW+1:2]]   = inst;
        ref_taken[pc[IMEM_AW+1:2]]  = taken;
        ref_target[pc[IMEM_AW+1:2]] = target;
    endtask

    // ========================================
    // instruction port, follows the predicted path from boot
    // ========================================
    task automatic collect_items(input string name, input xlen_t boot, input int count,
                                 input logic use_bp, input logic probe);
        xlen_t              exp_pc;
        logic [IMEM_AW-1:0] idx;
        int                 got;
        int                 idle;
        exp_pc = boot;
        got    = 0;
        idle   = 0;
        while (got < count) begin
            @(posedge clk);
            #1;
            ready_i = use_bp ? next_lfsr_bit() : 1'b1;
            if (probe) begin                // must stay blocked until the halt
                cfg_valid_i = 1'b1;
                cfg_op_i    = CFG_LOAD_WORD;
                cfg_addr_i  = patch_pc[0][IMEM_AW+1:2];
                cfg_data_i  = patch_inst[0];
            end
            @(negedge clk);
            if (probe) begin
                check_flag({name, ".cfg_ready"}, 1'b0, cfg_ready_o);
            end
            if (valid_o && ready_i) begin   // transfers on the coming edge
                idx = exp_pc[IMEM_AW+1:2];
                check_word({name, ".pc"}, exp_pc, pc_o);
                check_word({name, ".pc_plus4"}, exp_pc + 32'd4, pc_plus4_o);
                check_word({name, ".inst"}, ref_inst[idx], inst_o);
                check_flag({name, ".pred_taken"}, ref_taken[idx], pred_taken_o);
                check_word({name, ".pred_target"}, ref_target[idx], pred_target_o);
                exp_pc = ref_taken[idx] ? ref_target[idx] : exp_pc + 32'd4;
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > ITEM_TIMEOUT) begin
                    fail_run($sformatf("timeout: %s got no item after %0d of %0d",
                                       name, got, count));
                end
            end
        end
        @(posedge clk);
        #1;
        ready_i     = 1'b0;                 // hold whatever is left on the port
        cfg_valid_i = 1'b0;
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        resetn      = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_op_i    = CFG_LOAD_WORD;
        cfg_addr_i  = '0;
        cfg_data_i  = '0;
        ready_i     = 1'b0;
        lfsr_q      = 32'h5e0f_bf02;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        check_flag("reset.cfg_ready", 1'b1, cfg_ready_o);
        check_flag("reset.valid", 1'b0, valid_o);

        // background words everywhere, then the program on top
        for (int i = 0; i < DEPTH; i++) begin
            load_word(i * 4, fill_word(i), 1'b0, i * 4 + 4);
        end
        for (int i = 0; i < N_PROG; i++) begin
            load_word(prog_pc[i], prog_inst[i], prog_taken[i], prog_target[i]);
        end

        for (int t = 0; t < N_TEST; t++) begin
            if (t_patch[t]) begin
                for (int i = 0; i < N_PATCH; i++) begin
                    load_word(patch_pc[i], patch_inst[i], patch_taken[i], patch_target[i]);
                end
            end
            send_cfg(CFG_SET_BOOT, '0, t_boot[t]);
            send_cfg(CFG_RUN, '0, '0);
            collect_items(t_name[t], t_boot[t], t_count[t], t_bp[t], t_probe[t]);
            send_cfg(CFG_HALT, '0, '0);
            @(negedge clk);
            check_flag({t_name[t], ".valid_after_halt"}, 1'b0, valid_o);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule
